// ==== exec_patterns.txt ====
// unit pair func opb_sel lit opa opb npc br_func cond uncond disp dest rob tail expected flag mask
// unit 0 alu 1 mult 2 branch f end, flag squashed or rollback.en, mask bit 0 random ready
0 0 0 0 0 5 7 0 0 0 0 0 1 0 0 c 0 0
0 0 1 0 0 5 7 0 0 0 0 0 1 1 0 fffffffffffffffe 0 0
0 0 2 0 0 ff0 f0f 0 0 0 0 0 1 2 0 f00 0 0
0 0 3 1 f ff0 0 0 0 0 0 0 1 3 0 ff0 0 0
0 0 4 0 0 ff0 f0f 0 0 0 0 0 1 4 0 fff 0 0
0 0 5 0 0 0 ffffffffffffff00 0 0 0 0 0 1 5 0 ff 0 0
0 0 6 1 3c ff0 0 0 0 0 0 0 1 6 0 fcc 0 0
0 0 7 0 0 ffffffffffffffff f 0 0 0 0 0 1 7 0 f 0 0
0 0 8 1 3f 8000000000000000 0 0 0 0 0 0 1 8 0 1 0 0
0 0 9 0 0 1 104 0 0 0 0 0 1 9 0 10 0 0
0 0 a 1 4 8000000000000000 0 0 0 0 0 0 1 a 0 f800000000000000 0 0
0 0 b 0 0 1 ffffffffffffffff 0 0 0 0 0 1 b 0 1 0 0
0 0 c 1 2a 2a 0 0 0 0 0 0 1 c 0 1 0 0
0 0 d 0 0 ffffffffffffffff 1 0 0 0 0 0 1 d 0 0 0 0
0 0 e 0 0 ffffffffffffffff 1 0 0 0 0 0 1 e 0 1 0 0
0 0 e 1 3 5 0 0 0 0 0 0 1 f 0 0 0 0
0 0 f 1 5 5 0 0 0 0 0 0 1 10 0 1 0 0
1 0 0 0 0 3 5 0 0 0 0 0 2 b 0 f 0 0
1 0 0 0 0 ffffffffffffffff 2 0 0 0 0 0 2 c 0 fffffffffffffffe 0 0
1 0 0 0 0 100000000 100000000 0 0 0 0 0 2 d 0 0 0 0
1 0 0 1 10 123456789 0 0 0 0 0 0 2 e 0 1234567890 0 0
1 0 0 0 0 ffffffff ffffffff 0 0 0 0 0 2 f 0 fffffffe00000001 0 0
1 0 0 0 0 7 9 0 0 0 0 0 3 10 0 3f 0 1
1 0 0 0 0 a a 0 0 0 0 0 3 11 0 64 0 1
1 0 0 0 0 1000 1000 0 0 0 0 0 3 12 0 1000000 0 1
1 0 0 0 0 ff ff 0 0 0 0 0 3 13 0 fe01 0 1
1 0 0 0 0 2 3 0 0 0 0 0 3 14 0 6 0 1
2 0 0 2 0 2 0 1000 0 1 0 4 0 15 15 1010 1 0
2 0 0 2 0 0 0 1000 1 1 0 1fffff 0 16 16 ffc 1 0
2 0 0 2 0 8000000000000000 0 1000 2 1 0 8 0 17 17 1020 1 0
2 0 0 2 0 5 0 1000 3 1 0 0 0 18 18 1000 0 0
2 0 0 2 0 2 0 1000 4 1 0 1 0 19 19 1004 0 0
2 0 0 2 0 7 0 1000 5 1 0 2 0 1a 1a 1008 1 0
2 0 0 2 0 1 0 1000 6 1 0 3 0 1b 1b 100c 1 0
2 0 0 2 0 0 0 1000 7 1 0 5 0 1c 1c 1014 0 0
2 0 0 0 0 0 2003 1000 0 0 1 0 0 1d 1d 2000 1 0
2 0 0 0 0 0 3f 1000 1 0 0 0 0 1e 1e 3c 0 0
1 0 0 0 0 6 7 0 0 0 0 0 4 1 0 2a 0 0
1 0 0 0 0 3 3 0 0 0 0 0 4 4 0 9 1 0
1 0 0 0 0 4 4 0 0 0 0 0 4 5 0 10 1 0
0 1 0 0 0 1 1 0 0 0 0 0 4 6 0 2 1 0
2 0 0 2 0 0 0 3000 0 0 1 0 0 3 8 3000 1 0
1 0 0 0 0 2 2 0 0 0 0 0 4 7 0 4 0 0
f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== all.f ====
fu_pkg.sv
alu_unit.sv
mult_stage.sv
mult_unit.sv
branch_unit.sv
exec_units.sv
tb_clock_gen.sv
tb_exec_units.sv

// ==== tb_exec_units.sv ====
`default_nettype none

module tb_exec_units;
  import fu_pkg::*;

  localparam int num_mult_stages = 4;
  localparam int ncols           = 18;  // words per vector in the pattern file
  localparam int max_vectors     = 64;

  typedef struct packed {
    logic [xlen-1:0] result;
    fu_tag_t         tag;
    logic            rb;    // expected rollback.en, branch only
    logic [31:0]     mark;  // issue cycle less stall cycles, multiplier only
  } expect_t;

  logic clock;
  logic reset;
  logic [rob_idx_width-1:0] rob_tail;
  fu_op_t     alu_in, mult_in, br_in;
  logic       alu_in_valid, mult_in_valid, br_in_valid;
  logic       alu_in_ready, mult_in_ready, br_in_ready;
  fu_result_t alu_out, mult_out, br_out;
  logic       alu_out_valid, mult_out_valid, br_out_valid;
  logic       alu_out_ready, mult_out_ready, br_out_ready;
  rollback_t  rollback;

  logic [63:0] pat [0:ncols*max_vectors-1];
  expect_t     alu_exp[$];
  expect_t     mult_exp[$];
  expect_t     br_exp[$];
  expect_t     e;
  int          err_count [3];
  int          nvec;
  int          limit;
  int          cycles;
  int          stalls;
  int          v;
  logic        random_ready;
  logic [31:0] lcg_state;

  tb_clock_gen #(.period(40), .reset_cycles(10)) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  exec_units #(.num_mult_stages(num_mult_stages)) DUT (
    .clock          (clock),
    .reset          (reset),
    .rob_tail       (rob_tail),
    .alu_in         (alu_in),
    .alu_in_valid   (alu_in_valid),
    .alu_in_ready   (alu_in_ready),
    .alu_out        (alu_out),
    .alu_out_valid  (alu_out_valid),
    .alu_out_ready  (alu_out_ready),
    .mult_in        (mult_in),
    .mult_in_valid  (mult_in_valid),
    .mult_in_ready  (mult_in_ready),
    .mult_out       (mult_out),
    .mult_out_valid (mult_out_valid),
    .mult_out_ready (mult_out_ready),
    .br_in          (br_in),
    .br_in_valid    (br_in_valid),
    .br_in_ready    (br_in_ready),
    .br_out         (br_out),
    .br_out_valid   (br_out_valid),
    .br_out_ready   (br_out_ready),
    .rollback       (rollback)
  );

  function automatic logic next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[16];
  endfunction

  function automatic fu_op_t make_op(input int b);
    fu_op_t op;
    op.func          = alu_func_e'(pat[b+2][3:0]);
    op.opb_sel       = opb_sel_e'(pat[b+3][1:0]);
    op.lit           = pat[b+4][7:0];
    op.opa_value     = pat[b+5];
    op.opb_value     = pat[b+6];
    op.npc           = pat[b+7];
    op.br_func       = pat[b+8][2:0];
    op.cond_branch   = pat[b+9][0];
    op.uncond_branch = pat[b+10][0];
    op.br_disp       = pat[b+11][20:0];
    op.tag.dest_idx  = pat[b+12][reg_idx_width-1:0];
    op.tag.rob_idx   = pat[b+13][rob_idx_width-1:0];
    return op;
  endfunction

  task automatic compare_value(input int unit, input string sig,
                               input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s got %h expected %h", $time, sig, got, exp);
      err_count[unit]++;
    end
  endtask

  task automatic issue_vector(input int idx);
    int      b;
    fu_op_t  op;
    expect_t x;
    b        = idx * ncols;
    op       = make_op(b);
    x.result = pat[b+15];
    x.tag    = op.tag;
    x.rb     = pat[b+16][0];  // squashed flag, or rollback for a branch
    x.mark   = cycles - stalls;
    case (pat[b][3:0])
      4'h0: begin
        alu_in       = op;
        alu_in_valid = 1'b1;
        if (!x.rb) alu_exp.push_back(x);
      end
      4'h1: begin
        mult_in       = op;
        mult_in_valid = 1'b1;
        if (!x.rb) mult_exp.push_back(x);
      end
      default: begin
        br_in       = op;
        br_in_valid = 1'b1;
        rob_tail    = pat[b+14][rob_idx_width-1:0];
        br_exp.push_back(x);
      end
    endcase
  endtask

  // hold each valid until its handshake, ends on a falling edge
  task automatic wait_accept();
    logic alu_acc;
    logic mult_acc;
    logic br_acc;
    do begin
      @(posedge clock);
      alu_acc  = alu_in_valid && alu_in_ready;
      mult_acc = mult_in_valid && mult_in_ready;
      br_acc   = br_in_valid && br_in_ready;
      @(negedge clock);
      if (alu_acc) alu_in_valid = 1'b0;
      if (mult_acc) mult_in_valid = 1'b0;
      if (br_acc) br_in_valid = 1'b0;
      mult_out_ready = random_ready ? next_random() : 1'b1;
    end while (alu_in_valid || mult_in_valid || br_in_valid);
  endtask

  // results are sampled before the edge updates the pipeline
  always @(posedge clock) begin
    if (!reset) begin
      if (alu_out_valid && alu_out_ready) begin
        assert (alu_exp.size() > 0) else begin
          $display("alu gave a result that no op should have produced at %0t", $time);
          err_count[0]++;
        end
        if (alu_exp.size() > 0) begin
          e = alu_exp.pop_front();
          compare_value(0, "alu_out.result", alu_out.result, e.result);
          compare_value(0, "alu_out.tag", alu_out.tag, e.tag);
        end
      end
      if (mult_out_valid && mult_out_ready) begin
        assert (mult_exp.size() > 0) else begin
          $display("multiplier gave an extra or squashed product at %0t", $time);
          err_count[1]++;
        end
        if (mult_exp.size() > 0) begin
          e = mult_exp.pop_front();
          compare_value(1, "mult_out.result", mult_out.result, e.result);
          compare_value(1, "mult_out.tag", mult_out.tag, e.tag);
          compare_value(1, "mult_out latency", cycles - stalls - e.mark, num_mult_stages);
        end
      end
      if (mult_out_valid && !mult_out_ready) begin
        stalls <= stalls + 1;  // whole pipeline holds
      end
      if (br_out_valid && br_out_ready) begin
        assert (br_exp.size() > 0) else begin
          $display("branch unit gave a result with no branch issued at %0t", $time);
          err_count[2]++;
        end
        if (br_exp.size() > 0) begin
          e = br_exp.pop_front();
          compare_value(2, "br_out.result", br_out.result, e.result);
          compare_value(2, "br_out.tag", br_out.tag, e.tag);
          compare_value(2, "rollback.en", rollback.en, e.rb);
          if (e.rb) begin
            compare_value(2, "rollback.rob_idx", rollback.rob_idx, e.tag.rob_idx);
            compare_value(2, "rollback.tail_idx", rollback.tail_idx, rob_tail);
          end
        end
      end
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    rob_tail       = '0;
    alu_in         = '0;
    mult_in        = '0;
    br_in          = '0;
    alu_in_valid   = 1'b0;
    mult_in_valid  = 1'b0;
    br_in_valid    = 1'b0;
    alu_out_ready  = 1'b1;
    mult_out_ready = 1'b1;
    br_out_ready   = 1'b1;
    random_ready   = 1'b0;
    lcg_state      = 32'h1b6a;
    cycles         = 0;
    stalls         = 0;
    limit          = 0;
    err_count      = '{0, 0, 0};
    $readmemh("exec_patterns.txt", pat);
    nvec = 0;
    while (nvec < max_vectors && pat[nvec*ncols][3:0] !== 4'hf) nvec++;
    limit = nvec * (num_mult_stages + 4) + 200;

    @(negedge clock);
    while (reset) @(negedge clock);

    v = 0;
    while (v < nvec) begin
      random_ready = pat[v*ncols+17][0];
      do begin
        issue_vector(v);
        v++;
      end while (v < nvec && pat[(v-1)*ncols+1][0]);  // paired ops go in one cycle
      wait_accept();
    end

    random_ready   = 1'b0;
    mult_out_ready = 1'b1;
    while (alu_exp.size() + mult_exp.size() + br_exp.size() != 0) @(posedge clock);
    repeat (num_mult_stages + 2) @(posedge clock);  // catch late extra products

    $display("errors: alu %0d, mult %0d, branch %0d", err_count[0], err_count[1],
             err_count[2]);
    if (err_count[0] + err_count[1] + err_count[2] == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
  parameter int period       = 40,
  parameter int reset_cycles = 10
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;  // released on a rising edge
  end

endmodule

`default_nettype wire

// ==== exec_units.sv ====
`default_nettype none

module exec_units #(
  parameter int num_mult_stages = 4
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [fu_pkg::rob_idx_width-1:0] rob_tail,
  // alu
  input  fu_pkg::fu_op_t                   alu_in,
  input  logic                             alu_in_valid,
  output logic                             alu_in_ready,
  output fu_pkg::fu_result_t               alu_out,
  output logic                             alu_out_valid,
  input  logic                             alu_out_ready,
  // multiplier
  input  fu_pkg::fu_op_t                   mult_in,
  input  logic                             mult_in_valid,
  output logic                             mult_in_ready,
  output fu_pkg::fu_result_t               mult_out,
  output logic                             mult_out_valid,
  input  logic                             mult_out_ready,
  // branch
  input  fu_pkg::fu_op_t                   br_in,
  input  logic                             br_in_valid,
  output logic                             br_in_ready,
  output fu_pkg::fu_result_t               br_out,
  output logic                             br_out_valid,
  input  logic                             br_out_ready,
  output fu_pkg::rollback_t                rollback
);

  alu_unit u_alu (
    .clock     (clock),
    .reset     (reset),
    .in        (alu_in),
    .in_valid  (alu_in_valid),
    .in_ready  (alu_in_ready),
    .out       (alu_out),
    .out_valid (alu_out_valid),
    .out_ready (alu_out_ready),
    .rollback  (rollback)
  );

  mult_unit #(
    .num_mult_stages (num_mult_stages)
  ) u_mult (
    .clock     (clock),
    .reset     (reset),
    .in        (mult_in),
    .in_valid  (mult_in_valid),
    .in_ready  (mult_in_ready),
    .out       (mult_out),
    .out_valid (mult_out_valid),
    .out_ready (mult_out_ready),
    .rollback  (rollback)
  );

  // source of the rollback broadcast
  branch_unit u_br (
    .clock     (clock),
    .reset     (reset),
    .rob_tail  (rob_tail),
    .in        (br_in),
    .in_valid  (br_in_valid),
    .in_ready  (br_in_ready),
    .out       (br_out),
    .out_valid (br_out_valid),
    .out_ready (br_out_ready),
    .rollback  (rollback)
  );

endmodule

`default_nettype wire

// ==== branch_unit.sv ====
`default_nettype none

module branch_unit (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [fu_pkg::rob_idx_width-1:0] rob_tail,
  input  fu_pkg::fu_op_t                   in,
  input  logic                             in_valid,
  output logic                             in_ready,
  output fu_pkg::fu_result_t               out,
  output logic                             out_valid,
  input  logic                             out_ready,
  output fu_pkg::rollback_t                rollback
);
  import fu_pkg::*;

  logic [xlen-1:0] opa;
  logic [xlen-1:0] disp;
  logic            cond;
  logic            taken;

  assign opa = in.opa_value;

  always_comb begin
    case (in.br_func[1:0])
      2'b00:   cond = !opa[0];                    // low bit clear
      2'b01:   cond = (opa == '0);
      2'b10:   cond = opa[xlen-1];                // negative
      default: cond = opa[xlen-1] || (opa == '0); // at most zero
    endcase
    if (in.br_func[2]) begin
      cond = !cond;
    end
  end

  assign taken = in.uncond_branch || (in.cond_branch && cond);

  // word displacement, sign extended
  assign disp = {{(xlen-23){in.br_disp[20]}}, in.br_disp, 2'b00};

  always_comb begin
    out.tag = in.tag;
    if (in.opb_sel == opb_is_br_disp) begin
      out.result = in.npc + disp;
    end else begin
      out.result = {in.opb_value[xlen-1:2], 2'b00};  // jump through register
    end
  end

  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  assign rollback.en       = in_valid && in_ready && taken;
  assign rollback.rob_idx  = in.tag.rob_idx;
  assign rollback.tail_idx = rob_tail;

  // targets come from the displacement or a register, never the literal
  a_no_lit_target : assert property (
    @(posedge clock) disable iff (reset) in_valid |-> in.opb_sel != opb_is_lit
  );

endmodule

`default_nettype wire

// ==== mult_unit.sv ====
`default_nettype none

module mult_unit #(
  parameter int num_mult_stages = 4
) (
  input  logic               clock,
  input  logic               reset,
  input  fu_pkg::fu_op_t     in,
  input  logic               in_valid,
  output logic               in_ready,
  output fu_pkg::fu_result_t out,
  output logic               out_valid,
  input  logic               out_ready,
  input  fu_pkg::rollback_t  rollback
);
  import fu_pkg::*;

  // index 0 is the unit input, index num_mult_stages the last stage
  logic    [num_mult_stages:0]           valid_chain;
  logic    [num_mult_stages:0][xlen-1:0] product_chain;
  logic    [num_mult_stages:0][xlen-1:0] mplier_chain;
  logic    [num_mult_stages:0][xlen-1:0] mcand_chain;
  fu_tag_t [num_mult_stages:0]           tag_chain;
  logic                                  advance;
  logic                                  out_squash;

  if (xlen % num_mult_stages != 0) begin : g_bad_depth
    $error("num_mult_stages must divide %0d", xlen);
  end

  assign valid_chain[0]   = in_valid;
  assign product_chain[0] = '0;
  assign mplier_chain[0]  = in.opa_value;
  assign mcand_chain[0]   = int_opb(in);
  assign tag_chain[0]     = in.tag;  // stage 0 squashes this too

  assign advance  = out_ready || !valid_chain[num_mult_stages];  // all stages move together
  assign in_ready = advance;

  for (genvar i = 0; i < num_mult_stages; i++) begin : g_stage
    mult_stage #(
      .num_mult_stages (num_mult_stages),
      .tag_type        (fu_tag_t)
    ) u_stage (
      .clock       (clock),
      .reset       (reset),
      .advance     (advance),
      .squash_en   (rollback),
      .in_valid    (valid_chain[i]),
      .product_in  (product_chain[i]),
      .mplier_in   (mplier_chain[i]),
      .mcand_in    (mcand_chain[i]),
      .tag_in      (tag_chain[i]),
      .out_valid   (valid_chain[i+1]),
      .product_out (product_chain[i+1]),
      .mplier_out  (mplier_chain[i+1]),
      .mcand_out   (mcand_chain[i+1]),
      .tag_out     (tag_chain[i+1])
    );
  end

  // last stage must not leave while its branch resolves
  assign out_squash = rollback.en && rob_is_younger(tag_chain[num_mult_stages].rob_idx,
                                                    rollback.rob_idx, rollback.tail_idx);

  assign out_valid  = valid_chain[num_mult_stages] && !out_squash;
  assign out.result = product_chain[num_mult_stages];
  assign out.tag    = tag_chain[num_mult_stages];

  a_hold_on_stall : assert property (
    @(posedge clock) disable iff (reset)
      out_valid && !out_ready |=> $stable(out)
  );

endmodule

`default_nettype wire

// ==== mult_stage.sv ====
`default_nettype none

module mult_stage #(
  parameter int  num_mult_stages = 4,
  parameter type tag_type        = fu_pkg::fu_tag_t
) (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    advance,
  input  fu_pkg::rollback_t       squash_en,
  input  logic                    in_valid,
  input  logic [fu_pkg::xlen-1:0] product_in,
  input  logic [fu_pkg::xlen-1:0] mplier_in,
  input  logic [fu_pkg::xlen-1:0] mcand_in,
  input  tag_type                 tag_in,
  output logic                    out_valid,
  output logic [fu_pkg::xlen-1:0] product_out,
  output logic [fu_pkg::xlen-1:0] mplier_out,
  output logic [fu_pkg::xlen-1:0] mcand_out,
  output tag_type                 tag_out
);
  import fu_pkg::*;

  localparam int slice = xlen / num_mult_stages;  // multiplier bits per stage

  logic [xlen-1:0] partial;
  logic            next_valid;
  tag_type         next_tag;
  logic            squash;

  assign partial = xlen'(mplier_in[slice-1:0]) * mcand_in;

  // entry this stage holds after the edge
  assign next_valid = advance ? in_valid : out_valid;
  assign next_tag   = advance ? tag_in : tag_out;
  assign squash     = squash_en.en &&
                      rob_is_younger(next_tag.rob_idx, squash_en.rob_idx, squash_en.tail_idx);

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= next_valid && !squash;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      product_out <= product_in + partial;
      mplier_out  <= mplier_in >> slice;  // next slice to the bottom
      mcand_out   <= mcand_in << slice;
      tag_out     <= tag_in;
    end
  end

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`default_nettype none

module alu_unit (
  input  logic               clock,
  input  logic               reset,
  input  fu_pkg::fu_op_t     in,
  input  logic               in_valid,
  output logic               in_ready,
  output fu_pkg::fu_result_t out,
  output logic               out_valid,
  input  logic               out_ready,
  input  fu_pkg::rollback_t  rollback
);
  import fu_pkg::*;

  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb;
  logic [5:0]      shamt;
  logic            signed_lt;
  logic            squash;

  assign opa       = in.opa_value;
  assign opb       = int_opb(in);
  assign shamt     = opb[5:0];
  assign signed_lt = $signed(opa) < $signed(opb);

  always_comb begin
    out.tag = in.tag;
    case (in.func)
      alu_addq:   out.result = opa + opb;
      alu_subq:   out.result = opa - opb;
      alu_and:    out.result = opa & opb;
      alu_bic:    out.result = opa & ~opb;
      alu_bis:    out.result = opa | opb;
      alu_ornot:  out.result = opa | ~opb;
      alu_xor:    out.result = opa ^ opb;
      alu_eqv:    out.result = opa ^ ~opb;
      alu_srl:    out.result = opa >> shamt;
      alu_sll:    out.result = opa << shamt;
      alu_sra:    out.result = $signed(opa) >>> shamt;  // sign fill from bit 63
      alu_cmpult: out.result = {{(xlen-1){1'b0}}, opa < opb};
      alu_cmpeq:  out.result = {{(xlen-1){1'b0}}, opa == opb};
      alu_cmpule: out.result = {{(xlen-1){1'b0}}, opa <= opb};
      alu_cmplt:  out.result = {{(xlen-1){1'b0}}, signed_lt};
      alu_cmple:  out.result = {{(xlen-1){1'b0}}, signed_lt || (opa == opb)};
      default:    out.result = '0;
    endcase
  end

  // younger than a branch resolving this cycle
  assign squash = rollback.en &&
                  rob_is_younger(in.tag.rob_idx, rollback.rob_idx, rollback.tail_idx);

  assign out_valid = in_valid && !squash;
  assign in_ready  = out_ready;  // no storage, back-pressure passes through

  // a stalled op stays put until it transfers
  a_in_held_on_stall : assert property (
    @(posedge clock) disable iff (reset) in_valid && !in_ready |=> in_valid && $stable(in)
  );

endmodule

`default_nettype wire

// ==== fu_pkg.sv ====
`default_nettype none

package fu_pkg;

  localparam int xlen          = 64;
  localparam int rob_idx_width = 5;
  localparam int reg_idx_width = 5;

  typedef enum logic [3:0] {
    alu_addq,
    alu_subq,
    alu_and,
    alu_bic,
    alu_bis,
    alu_ornot,
    alu_xor,
    alu_eqv,
    alu_srl,
    alu_sll,
    alu_sra,
    alu_cmpult,
    alu_cmpeq,
    alu_cmpule,
    alu_cmplt,
    alu_cmple
  } alu_func_e;

  typedef enum logic [1:0] {
    opb_is_reg,     // opb_value
    opb_is_lit,     // zero-extended 8-bit literal
    opb_is_br_disp  // branch displacement
  } opb_sel_e;

  // follows an op all the way to its result
  typedef struct packed {
    logic [reg_idx_width-1:0] dest_idx;
    logic [rob_idx_width-1:0] rob_idx;
  } fu_tag_t;

  typedef struct packed {
    alu_func_e       func;
    opb_sel_e        opb_sel;
    logic [7:0]      lit;
    logic [xlen-1:0] opa_value;
    logic [xlen-1:0] opb_value;
    logic [xlen-1:0] npc;
    logic [2:0]      br_func;
    logic            cond_branch;
    logic            uncond_branch;
    logic [20:0]     br_disp;
    fu_tag_t         tag;
  } fu_op_t;

  typedef struct packed {
    logic [xlen-1:0] result;
    fu_tag_t         tag;
  } fu_result_t;

  typedef struct packed {
    logic                     en;
    logic [rob_idx_width-1:0] rob_idx;   // the branch
    logic [rob_idx_width-1:0] tail_idx;  // rob tail when the branch resolved
  } rollback_t;

  // distances are taken from the branch, wrapping around the rob
  function automatic logic rob_is_younger(
    input logic [rob_idx_width-1:0] op_idx,
    input logic [rob_idx_width-1:0] br_idx,
    input logic [rob_idx_width-1:0] tail_idx
  );
    logic [rob_idx_width-1:0] op_dist;
    logic [rob_idx_width-1:0] tail_dist;
    op_dist   = op_idx - br_idx;
    tail_dist = tail_idx - br_idx;
    return (op_dist != '0) && (op_dist <= tail_dist);
  endfunction

  // operand b for the alu and the multiplier
  function automatic logic [xlen-1:0] int_opb(input fu_op_t op);
    return (op.opb_sel == opb_is_lit) ? {{(xlen-8){1'b0}}, op.lit} : op.opb_value;
  endfunction

endpackage

`default_nettype wire
